//--- common/lnk_macros.svh
`ifndef LNK_MACROS_SVH
`define LNK_MACROS_SVH

// ########################################
// packet field widths
// ########################################
`define LNK_CW 32 // command
`define LNK_AW 64 // dst/src address
`define LNK_DW 64 // single-beat data

// ########################################
// group decode
// ########################################
// group field sits in the destination address
`define LNK_GRPOFFSET 24
`define LNK_GRPAW 8
`define LNK_GRPID 8'h5a // this endpoint's group

// ########################################
// register target
// ########################################
`define LNK_NREGS 8 // indexed by dstaddr[5:3]

`endif

//--- common/lnk_pkg.sv
`default_nettype none

`include "lnk_macros.svh"

package lnk_pkg;

   typedef logic [`LNK_CW-1:0] cmd_t;          // opcode in low byte
   typedef logic [`LNK_AW-1:0] addr_t;
   typedef logic [`LNK_DW-1:0] data_t;
   typedef logic [`LNK_GRPAW-1:0] grp_t;

   // one bit per crossbar port, bit 0 core, bit 1 phy, bit 2 regs
   typedef logic [2:0] port_mask_t;

   typedef enum logic [7:0] {
      READ   = 8'd1,
      WRITE  = 8'd2,
      RDRESP = 8'd3, // read response, carries data
      WRACK  = 8'd4  // write ack, data is zero
   } opcode_e;

   // full single-beat packet, 224 bits
   typedef struct packed {
      cmd_t  cmd;
      addr_t dstaddr;
      addr_t srcaddr;
      data_t data;
   } pkt_t;

   // register responder
   typedef enum logic {
      IDLE, // ready for a request
      RESP  // response pending
   } resp_state_e;

endpackage

`default_nettype wire

//--- design/lnk_route_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lnk_macros.svh"

module lnk_route_decode (
   input  wire logic                devicemode, // 1 = phy side starts accesses
   input  wire lnk_pkg::port_mask_t in_valid,
   input  wire lnk_pkg::pkt_t       in_pkt [3],
   output lnk_pkg::port_mask_t      request [3], // per input, bit per output
   output lnk_pkg::port_mask_t      discard
);

   localparam int CORE = 0;
   localparam int PHY  = 1;
   localparam int REGS = 2;
   localparam lnk_pkg::grp_t GRPID = `LNK_GRPID;

   lnk_pkg::port_mask_t grp_hit; // dst group equals ours

   always_comb begin
      for (int i = 0; i < 3; i++) begin
         grp_hit[i] = (in_pkt[i].dstaddr[`LNK_GRPOFFSET +: `LNK_GRPAW] == GRPID);
      end
   end

   // ########################################
   // mode table
   // ########################################
   always_comb begin
      for (int i = 0; i < 3; i++) begin
         request[i] = '0;
      end
      if (!devicemode) begin
         // host: core initiates
         request[CORE][REGS] = grp_hit[CORE];
         request[CORE][PHY]  = ~grp_hit[CORE];
         request[PHY][CORE]  = ~grp_hit[PHY];  // local group from phy goes nowhere
         request[REGS][CORE] = 1'b1;           // responses back to core
      end else begin
         // device: phy initiates
         request[PHY][REGS]  = grp_hit[PHY];
         request[PHY][CORE]  = ~grp_hit[PHY];
         request[CORE][PHY]  = ~grp_hit[CORE]; // local group from core dropped
         request[REGS][PHY]  = 1'b1;           // responses back to phy
      end
      for (int i = 0; i < 3; i++) begin
         if (!in_valid[i]) request[i] = '0;  // idle input asks nothing
         discard[i] = in_valid[i] & ~(|request[i]); // valid, but no route
      end
   end

endmodule

`default_nettype wire

//--- crossbar/lnk_xbar_arb.sv
`timescale 1ns/1ps
`default_nettype none

module lnk_xbar_arb (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire lnk_pkg::port_mask_t request,   // bit per input
   input  wire logic                out_ready,
   output lnk_pkg::port_mask_t      grant,     // one-hot or zero
   output logic                     out_valid
);

   lnk_pkg::port_mask_t last;      // previous winner, one-hot
   lnk_pkg::port_mask_t hi_mask;   // inputs above last winner
   lnk_pkg::port_mask_t hi_req;
   lnk_pkg::port_mask_t pick_src;
   lnk_pkg::port_mask_t next_grant;
   logic                hold;

   // granted input still asking for this output
   assign out_valid = |(grant & request);

   // stalled transfer keeps its grant
   assign hold = out_valid & ~out_ready;

   // ########################################
   // round robin pick
   // ########################################
   always_comb begin
      hi_mask  = ~(last | (last - 3'd1)); // zero after reset
      hi_req   = request & hi_mask;
      pick_src = (|hi_req) ? hi_req : request; // wrap around
      next_grant = pick_src & (~pick_src + 3'd1); // lowest set bit
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         grant <= '0;
         last  <= '0;
      end else if (!hold) begin
         grant <= next_grant; // idle or just completed
         if (|next_grant) last <= next_grant;
      end
   end

endmodule

`default_nettype wire

//--- crossbar/lnk_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module lnk_xbar (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire lnk_pkg::port_mask_t request [3], // per input, bit per output
   input  wire lnk_pkg::port_mask_t discard,
   input  wire lnk_pkg::pkt_t       in_pkt [3],
   output lnk_pkg::port_mask_t      in_ready,
   output lnk_pkg::port_mask_t      out_valid,
   output lnk_pkg::pkt_t            out_pkt [3],
   input  wire lnk_pkg::port_mask_t out_ready
);

   lnk_pkg::port_mask_t out_req [3]; // per output, bit per input
   lnk_pkg::port_mask_t grant   [3]; // per output, one-hot input
   logic                arb_valid [3];

   // ########################################
   // request transpose
   // ########################################
   always_comb begin
      for (int o = 0; o < 3; o++) begin
         for (int i = 0; i < 3; i++) begin
            out_req[o][i] = request[i][o];
         end
      end
   end

   // one arbiter per output
   for (genvar o = 0; o < 3; o++) begin : g_arb
      lnk_xbar_arb u_arb (
         .clk       (clk),
         .rst_n     (rst_n),
         .request   (out_req[o]),
         .out_ready (out_ready[o]),
         .grant     (grant[o]),
         .out_valid (arb_valid[o])
      );
   end

   // ########################################
   // output mux
   // ########################################
   always_comb begin
      for (int o = 0; o < 3; o++) begin
         out_valid[o] = arb_valid[o];
         out_pkt[o]   = '0;
         for (int i = 0; i < 3; i++) begin
            if (grant[o][i]) out_pkt[o] = in_pkt[i]; // grant is one-hot
         end
      end
   end

   // ready back to inputs
   always_comb begin
      for (int i = 0; i < 3; i++) begin
         in_ready[i] = discard[i]; // dropped packets are swallowed
         for (int o = 0; o < 3; o++) begin
            // stale grant to an input now targeting elsewhere gives no ready
            if (grant[o][i] && request[i][o] && out_ready[o]) begin
               in_ready[i] = 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- design/lnk_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "lnk_macros.svh"

module lnk_reg_file (
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  wire logic          req_valid,
   input  wire lnk_pkg::pkt_t req_pkt,
   output logic               req_ready,
   output logic               resp_valid,
   output lnk_pkg::pkt_t      resp_pkt,
   input  wire logic          resp_ready
);

   localparam int IDXW    = $clog2(`LNK_NREGS);
   localparam int IDX_LSB = 3; // 64-bit registers, dstaddr[5:3]

   lnk_pkg::resp_state_e state;
   lnk_pkg::data_t       regs [`LNK_NREGS];
   logic [IDXW-1:0]      idx;
   lnk_pkg::opcode_e     op;
   logic                 accept;
   logic                 is_write;

   assign req_ready  = (state == lnk_pkg::IDLE);  // one request in flight
   assign resp_valid = (state == lnk_pkg::RESP);
   assign accept     = req_valid & req_ready;

   // ########################################
   // request decode
   // ########################################
   assign idx = req_pkt.dstaddr[IDX_LSB +: IDXW];
   assign op  = lnk_pkg::opcode_e'(req_pkt.cmd[7:0]);

   always_comb begin
      case (op)
         lnk_pkg::WRITE: is_write = 1'b1;
         lnk_pkg::READ:  is_write = 1'b0;
         default:        is_write = 1'b0; // unknown ops answer as reads
      endcase
   end

   // state and register storage
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= lnk_pkg::IDLE;
         for (int r = 0; r < `LNK_NREGS; r++) begin
            regs[r] <= '0;
         end
      end else begin
         case (state)
            lnk_pkg::IDLE: begin
               if (accept) state <= lnk_pkg::RESP;
               if (accept && is_write) regs[idx] <= req_pkt.data;
            end
            lnk_pkg::RESP: begin
               if (resp_ready) state <= lnk_pkg::IDLE; // response taken
            end
            default: state <= lnk_pkg::IDLE;
         endcase
      end
   end

   // ########################################
   // response packet
   // ########################################
   always_ff @(posedge clk) begin
      if (accept) begin
         resp_pkt.dstaddr <= req_pkt.srcaddr; // back to requester
         resp_pkt.srcaddr <= req_pkt.dstaddr;
         if (is_write) begin
            resp_pkt.cmd  <= lnk_pkg::cmd_t'(lnk_pkg::WRACK);
            resp_pkt.data <= '0;
         end else begin
            resp_pkt.cmd  <= lnk_pkg::cmd_t'(lnk_pkg::RDRESP);
            resp_pkt.data <= regs[idx]; // value before this cycle
         end
      end
   end

endmodule

`default_nettype wire

//--- design/lnk_top.sv
`timescale 1ns/1ps
`default_nettype none

module lnk_top (
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  wire logic          devicemode, // 0 host, 1 device
   // core side
   input  wire logic          core_in_valid,
   input  wire lnk_pkg::pkt_t core_in_pkt,
   output logic               core_in_ready,
   output logic               core_out_valid,
   output lnk_pkg::pkt_t      core_out_pkt,
   input  wire logic          core_out_ready,
   // phy side
   input  wire logic          phy_in_valid,
   input  wire lnk_pkg::pkt_t phy_in_pkt,
   output logic               phy_in_ready,
   output logic               phy_out_valid,
   output lnk_pkg::pkt_t      phy_out_pkt,
   input  wire logic          phy_out_ready
);

   // crossbar side, index 0 core, 1 phy, 2 regs
   lnk_pkg::port_mask_t in_valid, in_ready, out_valid, out_ready, discard;
   lnk_pkg::pkt_t       in_pkt [3];
   lnk_pkg::pkt_t       out_pkt [3];
   lnk_pkg::port_mask_t request [3];
   // register target link
   logic                regs_req_ready, regs_resp_valid;
   lnk_pkg::pkt_t       regs_resp_pkt;

   assign in_valid  = {regs_resp_valid, phy_in_valid, core_in_valid};
   assign in_pkt[0] = core_in_pkt;
   assign in_pkt[1] = phy_in_pkt;
   assign in_pkt[2] = regs_resp_pkt;
   assign out_ready = {regs_req_ready, phy_out_ready, core_out_ready};

   assign core_in_ready  = in_ready[0];
   assign phy_in_ready   = in_ready[1];
   assign core_out_valid = out_valid[0];
   assign core_out_pkt   = out_pkt[0];
   assign phy_out_valid  = out_valid[1];
   assign phy_out_pkt    = out_pkt[1];

   lnk_route_decode u_decode (
      .devicemode (devicemode),
      .in_valid   (in_valid),
      .in_pkt     (in_pkt),
      .request    (request),
      .discard    (discard)
   );

   lnk_xbar u_xbar (
      .clk       (clk),
      .rst_n     (rst_n),
      .request   (request),
      .discard   (discard),
      .in_pkt    (in_pkt),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_pkt   (out_pkt),
      .out_ready (out_ready)
   );

   lnk_reg_file u_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (out_valid[2]),
      .req_pkt    (out_pkt[2]),
      .req_ready  (regs_req_ready),
      .resp_valid (regs_resp_valid),
      .resp_pkt   (regs_resp_pkt),
      .resp_ready (in_ready[2])
   );

endmodule

`default_nettype wire

//--- test/lnk_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lnk_clk_gen (
   output logic clk
);

   localparam int HALF_NS = 20; // 40 ns period

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

endmodule

`default_nettype wire

//--- test/lnk_chk.sv
`timescale 1ns/1ps
`default_nettype none

module lnk_chk (
   input wire logic                clk,
   input wire logic                rst_n,
   input wire lnk_pkg::port_mask_t grant [3],  // per output, one-hot input
   input wire lnk_pkg::port_mask_t out_valid,
   input wire lnk_pkg::port_mask_t out_ready,
   input wire lnk_pkg::pkt_t       out_pkt [3]
);

   for (genvar o = 0; o < 3; o++) begin : g_out
      // arbiter never serves two inputs at once
      a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
         $onehot0(grant[o]))
         else $error("grant of output %0d is not one-hot", o);

      // stalled output holds valid and packet
      a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
         (out_valid[o] && !out_ready[o]) |=> (out_valid[o] && $stable(out_pkt[o])))
         else $error("output %0d changed while stalled", o);
   end

   // nothing leaves the crossbar right after reset
   a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (out_valid == 3'b000))
      else $error("out_valid high in the cycle after reset");

endmodule

bind lnk_xbar lnk_chk u_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .grant     (grant),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_pkt   (out_pkt)
);

`default_nettype wire

//--- test/lnk_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lnk_macros.svh"

module lnk_tb;

   localparam int CW           = $bits(lnk_pkg::pkt_t); // widest compared value
   localparam int CORE         = 0;
   localparam int PHY          = 1;
   localparam int WAIT_MAX     = 50;  // cycles for one handshake
   localparam int QUIET        = 20;
   localparam int STALL        = 8;
   localparam int N_TESTS      = 5;
   localparam int CYC_PER_TEST = 200;

   logic           clk;
   logic           rst_n;
   logic           devicemode;
   logic           core_in_valid, core_in_ready, core_out_valid, core_out_ready;
   logic           phy_in_valid, phy_in_ready, phy_out_valid, phy_out_ready;
   lnk_pkg::pkt_t  core_in_pkt, core_out_pkt, phy_in_pkt, phy_out_pkt;
   logic [31:0]    lfsr_state;
   lnk_pkg::data_t reg_model [`LNK_NREGS]; // expected register contents

   lnk_clk_gen u_clk_gen (.clk (clk));

   lnk_top u_lnk_top (
      .clk            (clk),
      .rst_n          (rst_n),
      .devicemode     (devicemode),
      .core_in_valid  (core_in_valid),
      .core_in_pkt    (core_in_pkt),
      .core_in_ready  (core_in_ready),
      .core_out_valid (core_out_valid),
      .core_out_pkt   (core_out_pkt),
      .core_out_ready (core_out_ready),
      .phy_in_valid   (phy_in_valid),
      .phy_in_pkt     (phy_in_pkt),
      .phy_in_ready   (phy_in_ready),
      .phy_out_valid  (phy_out_valid),
      .phy_out_pkt    (phy_out_pkt),
      .phy_out_ready  (phy_out_ready)
   );

   // ########################################
   // random values and checking
   // ########################################
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[62:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0); // galois taps
      end
      return v;
   endfunction

   function automatic lnk_pkg::addr_t local_addr(input logic [2:0] idx);
      lnk_pkg::addr_t a;
      a = rand_bits(64);
      a[`LNK_GRPOFFSET +: `LNK_GRPAW] = `LNK_GRPID;
      a[5:3] = idx; // register index
      return a;
   endfunction

   function automatic lnk_pkg::addr_t remote_addr();
      lnk_pkg::addr_t a;
      a = rand_bits(64);
      if (a[`LNK_GRPOFFSET +: `LNK_GRPAW] == `LNK_GRPID) begin
         a[`LNK_GRPOFFSET +: `LNK_GRPAW] = ~a[`LNK_GRPOFFSET +: `LNK_GRPAW]; // force a miss
      end
      return a;
   endfunction

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_eq(input string name, input logic [CW-1:0] got,
                           input logic [CW-1:0] want);
      if (got !== want) begin
         $display("[FAIL] %s got %h expected %h", name, got, want);
         abort_run();
      end
   endtask

   // ########################################
   // port handshakes
   // ########################################
   task automatic send_pkt(input int port, input lnk_pkg::pkt_t p);
      int   waited;
      logic rdy;
      waited = 0;
      rdy    = 1'b0;
      @(negedge clk);
      if (port == CORE) begin
         core_in_valid = 1'b1;
         core_in_pkt   = p;
      end else begin
         phy_in_valid = 1'b1;
         phy_in_pkt   = p;
      end
      while (!rdy) begin
         @(posedge clk);
         rdy    = (port == CORE) ? core_in_ready : phy_in_ready; // taken at this edge
         waited = waited + 1;
         if (!rdy && waited >= WAIT_MAX) begin
            $display("input port %0d never accepted its packet", port);
            abort_run();
         end
      end
      @(negedge clk);
      if (port == CORE) core_in_valid = 1'b0;
      else phy_in_valid = 1'b0;
   endtask

   task automatic wait_out(input int port, output lnk_pkg::pkt_t got);
      int   waited;
      logic vld;
      waited = 0;
      vld    = 1'b0;
      while (!vld) begin
         @(posedge clk);
         vld    = (port == CORE) ? core_out_valid : phy_out_valid;
         got    = (port == CORE) ? core_out_pkt : phy_out_pkt;
         waited = waited + 1;
         if (!vld && waited >= WAIT_MAX) begin
            $display("no packet showed up on output port %0d", port);
            abort_run();
         end
      end
   endtask

   task automatic recv_check(input int port, input lnk_pkg::pkt_t want);
      lnk_pkg::pkt_t got;
      wait_out(port, got);
      if (port == CORE) check_eq("core_out_pkt", got, want);
      else check_eq("phy_out_pkt", got, want);
   endtask

   task automatic expect_quiet(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         check_eq("core_out_valid", CW'(core_out_valid), CW'(1'b0));
         check_eq("phy_out_valid", CW'(phy_out_valid), CW'(1'b0));
      end
   endtask

   task automatic set_mode(input logic m);
      @(negedge clk);
      devicemode = m;
   endtask

   // ########################################
   // packet builders
   // ########################################
   // response swaps addresses and puts its opcode in the low byte only
   task automatic build_req(input lnk_pkg::opcode_e op, input logic [2:0] idx,
                            output lnk_pkg::pkt_t req, output lnk_pkg::pkt_t want);
      req.cmd      = lnk_pkg::cmd_t'(op);
      req.dstaddr  = local_addr(idx);
      req.srcaddr  = rand_bits(64);
      req.data     = rand_bits(64);
      want.cmd     = (op == lnk_pkg::WRITE) ? lnk_pkg::cmd_t'(lnk_pkg::WRACK)
                                            : lnk_pkg::cmd_t'(lnk_pkg::RDRESP);
      want.dstaddr = req.srcaddr;
      want.srcaddr = req.dstaddr;
      want.data    = (op == lnk_pkg::WRITE) ? '0 : reg_model[idx];
   endtask

   task automatic reg_access(input int port, input lnk_pkg::opcode_e op,
                             input logic [2:0] idx);
      lnk_pkg::pkt_t req;
      lnk_pkg::pkt_t want;
      build_req(op, idx, req, want);
      fork
         send_pkt(port, req);
         recv_check(port, want); // answer goes back to the initiator
      join
      if (op == lnk_pkg::WRITE) reg_model[idx] = req.data;
   endtask

   task automatic pass_through(input int src, input int dst);
      lnk_pkg::pkt_t p;
      p.cmd     = lnk_pkg::cmd_t'(rand_bits(32));
      p.dstaddr = remote_addr();
      p.srcaddr = rand_bits(64);
      p.data    = rand_bits(64);
      fork
         send_pkt(src, p);
         recv_check(dst, p); // forwarded unchanged
      join
   endtask

   // ########################################
   // directed tests
   // ########################################
   task automatic host_reg_rw();
      logic [2:0] idx;
      set_mode(1'b0);
      idx = 3'(rand_bits(3));
      reg_access(CORE, lnk_pkg::WRITE, idx);
      reg_access(CORE, lnk_pkg::READ, idx);
   endtask

   task automatic host_forwarding();
      set_mode(1'b0);
      pass_through(CORE, PHY);
      pass_through(PHY, CORE);
   endtask

   task automatic device_reg_rw();
      logic [2:0] idx;
      set_mode(1'b1);
      idx = 3'(rand_bits(3));
      reg_access(PHY, lnk_pkg::WRITE, idx);
      reg_access(PHY, lnk_pkg::READ, idx);
      pass_through(PHY, CORE);
   endtask

   // core packet and register answer both head for a stalled phy_out
   task automatic device_stall();
      lnk_pkg::pkt_t a;
      lnk_pkg::pkt_t b;
      lnk_pkg::pkt_t r;
      lnk_pkg::pkt_t first;
      lnk_pkg::pkt_t got0;
      lnk_pkg::pkt_t got1;
      logic [2:0]    idx;
      set_mode(1'b1);
      idx       = 3'(rand_bits(3));
      a.cmd     = lnk_pkg::cmd_t'(rand_bits(32));
      a.dstaddr = remote_addr();
      a.srcaddr = rand_bits(64);
      a.data    = rand_bits(64);
      build_req(lnk_pkg::READ, idx, b, r);
      @(negedge clk);
      phy_out_ready = 1'b0;
      fork
         send_pkt(CORE, a);
         send_pkt(PHY, b);
         begin
            wait_out(PHY, first);
            if ((first !== a) && (first !== r)) begin
               $display("phy_out stalled on a packet that was never sent");
               abort_run();
            end
            repeat (STALL) begin
               @(posedge clk);
               check_eq("phy_out_valid", CW'(phy_out_valid), CW'(1'b1));
               check_eq("phy_out_pkt", phy_out_pkt, first); // frozen while stalled
            end
            @(negedge clk);
            phy_out_ready = 1'b1;
            wait_out(PHY, got0);
            wait_out(PHY, got1);
         end
      join
      if (!(((got0 === a) && (got1 === r)) || ((got0 === r) && (got1 === a)))) begin
         $display("phy_out did not deliver the two stalled packets once each");
         abort_run();
      end
      expect_quiet(QUIET);
   endtask

   task automatic discard_local();
      lnk_pkg::pkt_t p;
      lnk_pkg::pkt_t no_resp;
      logic [2:0]    idx;
      set_mode(1'b0);
      idx = 3'(rand_bits(3));
      reg_access(CORE, lnk_pkg::WRITE, idx); // value that must survive
      build_req(lnk_pkg::WRITE, idx, p, no_resp);
      send_pkt(PHY, p);  // local group from phy in host mode
      expect_quiet(QUIET);
      set_mode(1'b1);
      build_req(lnk_pkg::WRITE, idx, p, no_resp);
      send_pkt(CORE, p); // local group from core in device mode
      expect_quiet(QUIET);
      reg_access(PHY, lnk_pkg::READ, idx);
   endtask

   // ########################################
   // main sequence and watchdog
   // ########################################
   initial begin
      rst_n          = 1'b0;
      devicemode     = 1'b0;
      core_in_valid  = 1'b0;
      core_in_pkt    = '0;
      core_out_ready = 1'b1;
      phy_in_valid   = 1'b0;
      phy_in_pkt     = '0;
      phy_out_ready  = 1'b1;
      lfsr_state     = 32'h1a46e08c;
      for (int r = 0; r < `LNK_NREGS; r++) begin
         reg_model[r] = '0; // cleared by reset
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      host_reg_rw();
      host_forwarding();
      device_reg_rw();
      device_stall();
      discard_local();
      repeat (2) @(posedge clk);
      $display("Simulation finished: PASS");
      $finish;
   end

   initial begin
      repeat (N_TESTS * CYC_PER_TEST) @(posedge clk);
      $display("watchdog expired before the tests completed");
      abort_run();
   end

endmodule

`default_nettype wire

//--- lnk_xbar.f
+incdir+common
common/lnk_pkg.sv
design/lnk_route_decode.sv
crossbar/lnk_xbar_arb.sv
crossbar/lnk_xbar.sv
design/lnk_reg_file.sv
design/lnk_top.sv
test/lnk_clk_gen.sv
test/lnk_chk.sv
test/lnk_tb.sv

//--- run.sh
#!/bin/sh
# build and run the crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module lnk_tb -f lnk_xbar.f -o lnk_sim \
   && ./obj_dir/lnk_sim \
   || exit 1
